/* rtl/bedrock_two_fifo.sv */
`timescale 1ns/1ps

module bedrock_two_fifo #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     arst_n_i,

  input  payload_t data_i,
  input  logic     v_i,
  output logic     ready_and_o,

  output payload_t data_o,
  output logic     v_o,
  input  logic     ready_and_i
);

  payload_t mem_r [2];                  // storage, no reset
  logic     wr_ptr_r;
  logic     rd_ptr_r;
  logic     full_r;
  logic     empty;
  logic     enq;
  logic     deq;

  // pointers equal means empty unless the full flag is set
  assign empty       = (wr_ptr_r == rd_ptr_r) & ~full_r;
  assign ready_and_o = ~full_r;         // depends on state only
  assign v_o         = ~empty;
  assign data_o      = mem_r[rd_ptr_r];

  assign enq = v_i & ~full_r;
  assign deq = ready_and_i & ~empty;

  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_r[wr_ptr_r] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      full_r   <= 1'b0;
    end else begin
      if (enq) wr_ptr_r <= ~wr_ptr_r;
      if (deq) rd_ptr_r <= ~rd_ptr_r;
      if (enq & ~deq & (wr_ptr_r != rd_ptr_r)) begin
        full_r <= 1'b1;                 // second entry filled
      end else if (deq & ~enq) begin
        full_r <= 1'b0;
      end
    end
  end

endmodule

/* rtl/bedrock_wb_client.sv */
`timescale 1ns/1ps

module bedrock_wb_client (
  input  logic                                          clk_i,
  input  logic                                          arst_n_i,

  input  logic [bedrock_wb_pkg::wb_addr_width_lp-1:0]   adr_i,
  input  logic [bedrock_wb_pkg::data_width_lp-1:0]      dat_i,
  input  logic                                          cyc_i,
  input  logic                                          stb_i,
  input  logic [bedrock_wb_pkg::sel_width_lp-1:0]       sel_i,
  input  logic                                          we_i,
  output logic [bedrock_wb_pkg::data_width_lp-1:0]      dat_o,
  output logic                                          ack_o,

  output bedrock_wb_pkg::mem_header_s                   mem_cmd_header_o,
  output logic [bedrock_wb_pkg::data_width_lp-1:0]      mem_cmd_data_o,
  output logic                                          mem_cmd_v_o,
  input  logic                                          mem_cmd_ready_and_i,

  input  bedrock_wb_pkg::mem_header_s                   mem_resp_header_i,
  input  logic [bedrock_wb_pkg::data_width_lp-1:0]      mem_resp_data_i,
  input  logic                                          mem_resp_v_i,
  output logic                                          mem_resp_ready_and_o
);

  import bedrock_wb_pkg::*;

  logic                      pending_r;   // a command is out for this cycle
  logic                      cmd_v_r;
  logic                      ack_r;
  mem_header_s               hdr_r;
  logic [data_width_lp-1:0]  data_r;
  logic [data_width_lp-1:0]  dat_r;
  logic [lane_width_lp-1:0]  sel_offset;
  logic [lane_width_lp:0]    sel_count;
  mem_size_e                 sel_size;
  logic                      start;
  logic                      cmd_done;
  logic                      resp_done;
  logic [data_width_lp-1:0]  resp_lanes;

  // lowest selected lane gives the offset, lane count gives the size
  always_comb begin
    sel_offset = '0;
    sel_count  = '0;
    for (int i = sel_width_lp - 1; i >= 0; i--) begin
      if (sel_i[i]) sel_offset = lane_width_lp'(i);
    end
    for (int i = 0; i < sel_width_lp; i++) begin
      sel_count = sel_count + (lane_width_lp + 1)'(sel_i[i]);
    end
    case (sel_count)
      4'd1:    sel_size = e_size_1;
      4'd2:    sel_size = e_size_2;
      4'd4:    sel_size = e_size_4;
      default: sel_size = e_size_8;
    endcase
  end

  assign start                = cyc_i & stb_i & ~pending_r;
  assign cmd_done             = cmd_v_r & mem_cmd_ready_and_i;
  assign mem_resp_ready_and_o = pending_r & ~cmd_v_r & ~ack_r;
  assign resp_done            = mem_resp_v_i & mem_resp_ready_and_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_r <= 1'b0;
      cmd_v_r   <= 1'b0;
      ack_r     <= 1'b0;
    end else begin
      if (start) begin
        pending_r <= 1'b1;
        cmd_v_r   <= 1'b1;
      end else if (cmd_done) begin
        cmd_v_r   <= 1'b0;
      end
      ack_r <= resp_done;               // single cycle ack
      if (ack_r) pending_r <= 1'b0;     // cycle closes with the ack
    end
  end

  // response data back into the lanes of the original request
  assign resp_lanes = (mem_resp_data_i & byte_mask(lane_mask(hdr_r.size)))
                      << {hdr_r.addr[lane_width_lp-1:0], 3'b000};

  always_ff @(posedge clk_i) begin
    if (start) begin
      hdr_r  <= '{msg_type: (we_i ? e_mem_wr : e_mem_rd),
                  size:     sel_size,
                  addr:     {adr_i, sel_offset}};
      data_r <= (dat_i >> {sel_offset, 3'b000}) & byte_mask(lane_mask(sel_size));
    end
    if (resp_done) begin
      // write acks carry no data
      dat_r <= (mem_resp_header_i.msg_type == e_mem_wr) ? '0 : resp_lanes;
    end
  end

  assign mem_cmd_v_o      = cmd_v_r;
  assign mem_cmd_header_o = hdr_r;
  assign mem_cmd_data_o   = data_r;

  assign dat_o = dat_r;
  assign ack_o = ack_r;

endmodule

/* rtl/bedrock_wb_master.sv */
`timescale 1ns/1ps

module bedrock_wb_master (
  input  logic                                          clk_i,
  input  logic                                          arst_n_i,

  input  bedrock_wb_pkg::mem_header_s                   mem_cmd_header_i,
  input  logic [bedrock_wb_pkg::data_width_lp-1:0]      mem_cmd_data_i,
  input  logic                                          mem_cmd_v_i,
  output logic                                          mem_cmd_ready_and_o,

  output bedrock_wb_pkg::mem_header_s                   mem_resp_header_o,
  output logic [bedrock_wb_pkg::data_width_lp-1:0]      mem_resp_data_o,
  output logic                                          mem_resp_v_o,
  input  logic                                          mem_resp_ready_and_i,

  output logic [bedrock_wb_pkg::wb_addr_width_lp-1:0]   adr_o,
  output logic [bedrock_wb_pkg::data_width_lp-1:0]      dat_o,
  output logic                                          cyc_o,
  output logic                                          stb_o,
  output logic [bedrock_wb_pkg::sel_width_lp-1:0]       sel_o,
  output logic                                          we_o,
  input  logic [bedrock_wb_pkg::data_width_lp-1:0]      dat_i,
  input  logic                                          ack_i
);

  import bedrock_wb_pkg::*;

  typedef enum logic [1:0] {
    e_idle,
    e_bus,
    e_resp
  } state_e;

  state_e                    state_r;
  state_e                    state_n;
  logic                      ready_r;
  logic                      cmd_accept;
  mem_header_s               hdr_r;       // command held for the whole cycle
  logic [data_width_lp-1:0]  data_r;
  logic [data_width_lp-1:0]  resp_data_r;
  logic [lane_width_lp-1:0]  offset;
  logic [sel_width_lp-1:0]   lanes;
  logic [data_width_lp-1:0]  size_mask;
  logic                      is_wr;

  assign offset    = hdr_r.addr[lane_width_lp-1:0];
  assign lanes     = lane_mask(hdr_r.size);
  assign size_mask = byte_mask(lanes);
  assign is_wr     = (hdr_r.msg_type == e_mem_wr);

  assign mem_cmd_ready_and_o = ready_r;
  assign cmd_accept          = mem_cmd_v_i & ready_r;

  always_comb begin
    state_n = state_r;
    case (state_r)
      e_idle:  if (cmd_accept) state_n = e_bus;
      e_bus:   if (ack_i) state_n = e_resp;
      e_resp:  if (mem_resp_ready_and_i) state_n = e_idle;
      default: state_n = e_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_r <= e_idle;
      ready_r <= 1'b0;                  // low for a cycle out of reset
    end else begin
      state_r <= state_n;
      ready_r <= (state_n == e_idle);
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_accept) begin
      hdr_r  <= mem_cmd_header_i;
      data_r <= mem_cmd_data_i;
    end
    if ((state_r == e_bus) && ack_i) begin
      // realign read data to the LSB, writes return zero
      resp_data_r <= is_wr ? '0 : ((dat_i >> {offset, 3'b000}) & size_mask);
    end
  end

  // wishbone side
  assign cyc_o = (state_r == e_bus);
  assign stb_o = (state_r == e_bus);
  assign we_o  = is_wr;
  assign adr_o = hdr_r.addr[paddr_width_lp-1:lane_width_lp];
  assign sel_o = lanes << offset;
  assign dat_o = (data_r & size_mask) << {offset, 3'b000};   // into the selected lanes

  // response toward the FIFO
  assign mem_resp_v_o      = (state_r == e_resp);
  assign mem_resp_header_o = hdr_r;
  assign mem_resp_data_o   = resp_data_r;

endmodule

/* rtl/bedrock_wb_pkg.sv */
package bedrock_wb_pkg;

  localparam int paddr_width_lp   = 32;
  localparam int data_width_lp    = 64;
  localparam int sel_width_lp     = data_width_lp / 8;      // one bit per byte lane
  localparam int lane_width_lp    = $clog2(sel_width_lp);   // byte offset inside a word
  localparam int wb_addr_width_lp = paddr_width_lp - lane_width_lp;

  typedef enum logic {
    e_mem_rd = 1'b0,
    e_mem_wr = 1'b1
  } mem_msg_e;

  // log2 of the byte count
  typedef enum logic [1:0] {
    e_size_1 = 2'd0,
    e_size_2 = 2'd1,
    e_size_4 = 2'd2,
    e_size_8 = 2'd3
  } mem_size_e;

  typedef struct packed {
    mem_msg_e                  msg_type;
    mem_size_e                 size;
    logic [paddr_width_lp-1:0] addr;
  } mem_header_s;

  typedef struct packed {
    mem_header_s              header;
    logic [data_width_lp-1:0] data;
  } mem_beat_s;

  // lanes covered by a transfer of the given size, LSB aligned
  function automatic logic [sel_width_lp-1:0] lane_mask(mem_size_e size);
    case (size)
      e_size_1: return 8'h01;
      e_size_2: return 8'h03;
      e_size_4: return 8'h0f;
      default:  return 8'hff;
    endcase
  endfunction

  // widen a lane mask to a bit mask over the data beat
  function automatic logic [data_width_lp-1:0] byte_mask(logic [sel_width_lp-1:0] lanes);
    logic [data_width_lp-1:0] mask;
    mask = '0;
    for (int i = 0; i < sel_width_lp; i++) begin
      mask[i*8 +: 8] = {8{lanes[i]}};
    end
    return mask;
  endfunction

endpackage

/* rtl/bedrock_wb_top.sv */
`timescale 1ns/1ps

module bedrock_wb_top (
  input  logic                                       clk_i,
  input  logic                                       arst_n_i,

  input  bedrock_wb_pkg::mem_header_s                mem_cmd_header_i,
  input  logic [bedrock_wb_pkg::data_width_lp-1:0]   mem_cmd_data_i,
  input  logic                                       mem_cmd_v_i,
  output logic                                       mem_cmd_ready_and_o,

  output bedrock_wb_pkg::mem_header_s                mem_resp_header_o,
  output logic [bedrock_wb_pkg::data_width_lp-1:0]   mem_resp_data_o,
  output logic                                       mem_resp_v_o,
  input  logic                                       mem_resp_ready_and_i,

  output bedrock_wb_pkg::mem_header_s                c_mem_cmd_header_o,
  output logic [bedrock_wb_pkg::data_width_lp-1:0]   c_mem_cmd_data_o,
  output logic                                       c_mem_cmd_v_o,
  input  logic                                       c_mem_cmd_ready_and_i,

  input  bedrock_wb_pkg::mem_header_s                c_mem_resp_header_i,
  input  logic [bedrock_wb_pkg::data_width_lp-1:0]   c_mem_resp_data_i,
  input  logic                                       c_mem_resp_v_i,
  output logic                                       c_mem_resp_ready_and_o
);

  import bedrock_wb_pkg::*;

  // wishbone bus between the adapters
  logic [wb_addr_width_lp-1:0] wb_adr;
  logic [data_width_lp-1:0]    wb_dat_mosi;
  logic                        wb_cyc;
  logic                        wb_stb;
  logic [sel_width_lp-1:0]     wb_sel;
  logic                        wb_we;
  logic [data_width_lp-1:0]    wb_dat_miso;
  logic                        wb_ack;

  // master response into its FIFO
  mem_beat_s                   m_resp_beat;
  logic                        m_resp_v;
  logic                        m_resp_ready_and;
  mem_beat_s                   resp_beat_out;

  // client command into its FIFO
  mem_beat_s                   c_cmd_beat;
  logic                        c_cmd_v;
  logic                        c_cmd_ready_and;
  mem_beat_s                   cmd_beat_out;

  assign mem_resp_header_o  = resp_beat_out.header;
  assign mem_resp_data_o    = resp_beat_out.data;
  assign c_mem_cmd_header_o = cmd_beat_out.header;
  assign c_mem_cmd_data_o   = cmd_beat_out.data;

  bedrock_wb_master master_i (
    .clk_i                (clk_i),
    .arst_n_i             (arst_n_i),
    .mem_cmd_header_i     (mem_cmd_header_i),
    .mem_cmd_data_i       (mem_cmd_data_i),
    .mem_cmd_v_i          (mem_cmd_v_i),
    .mem_cmd_ready_and_o  (mem_cmd_ready_and_o),
    .mem_resp_header_o    (m_resp_beat.header),
    .mem_resp_data_o      (m_resp_beat.data),
    .mem_resp_v_o         (m_resp_v),
    .mem_resp_ready_and_i (m_resp_ready_and),
    .adr_o                (wb_adr),
    .dat_o                (wb_dat_mosi),
    .cyc_o                (wb_cyc),
    .stb_o                (wb_stb),
    .sel_o                (wb_sel),
    .we_o                 (wb_we),
    .dat_i                (wb_dat_miso),
    .ack_i                (wb_ack)
  );

  bedrock_two_fifo #(.payload_t(mem_beat_s)) resp_fifo_i (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .data_i      (m_resp_beat),
    .v_i         (m_resp_v),
    .ready_and_o (m_resp_ready_and),
    .data_o      (resp_beat_out),
    .v_o         (mem_resp_v_o),
    .ready_and_i (mem_resp_ready_and_i)
  );

  bedrock_wb_client client_i (
    .clk_i                (clk_i),
    .arst_n_i             (arst_n_i),
    .adr_i                (wb_adr),
    .dat_i                (wb_dat_mosi),
    .cyc_i                (wb_cyc),
    .stb_i                (wb_stb),
    .sel_i                (wb_sel),
    .we_i                 (wb_we),
    .dat_o                (wb_dat_miso),
    .ack_o                (wb_ack),
    .mem_cmd_header_o     (c_cmd_beat.header),
    .mem_cmd_data_o       (c_cmd_beat.data),
    .mem_cmd_v_o          (c_cmd_v),
    .mem_cmd_ready_and_i  (c_cmd_ready_and),
    .mem_resp_header_i    (c_mem_resp_header_i),
    .mem_resp_data_i      (c_mem_resp_data_i),
    .mem_resp_v_i         (c_mem_resp_v_i),
    .mem_resp_ready_and_o (c_mem_resp_ready_and_o)
  );

  bedrock_two_fifo #(.payload_t(mem_beat_s)) cmd_fifo_i (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .data_i      (c_cmd_beat),
    .v_i         (c_cmd_v),
    .ready_and_o (c_cmd_ready_and),
    .data_o      (cmd_beat_out),
    .v_o         (c_mem_cmd_v_o),
    .ready_and_i (c_mem_cmd_ready_and_i)
  );

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module bedrock_wb_tb \
  -o sim_bedrock_wb > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/sim_bedrock_wb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Errors found" sim.log; then
  exit 1
fi
exit 0

/* test/bedrock_wb_checker.sv */
`timescale 1ns/1ps

module bedrock_wb_checker (
  input logic                                    clk_i,
  input logic                                    arst_n_i,
  input logic                                    cyc_i,
  input logic                                    stb_i,
  input logic                                    ack_i,
  input logic [bedrock_wb_pkg::sel_width_lp-1:0] sel_i,
  input bedrock_wb_pkg::mem_header_s             resp_header_i,
  input logic [bedrock_wb_pkg::data_width_lp-1:0] resp_data_i,
  input logic                                    resp_v_i,
  input logic                                    resp_ready_i,
  input bedrock_wb_pkg::mem_header_s             c_cmd_header_i,
  input logic [bedrock_wb_pkg::data_width_lp-1:0] c_cmd_data_i,
  input logic                                    c_cmd_v_i,
  input logic                                    c_cmd_ready_i
);

  import bedrock_wb_pkg::*;

  logic [sel_width_lp-1:0] sel_low;
  int                      fail_count;
  assign sel_low = sel_i & (~sel_i + 1'b1);   // lowest set lane

  stb_hold_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (stb_i && !ack_i) |=> stb_i)
    else begin
      $error("stb dropped before ack");
      fail_count++;
    end

  ack_cyc_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ack_i |-> cyc_i)
    else begin
      $error("ack without cyc");
      fail_count++;
    end

  sel_contig_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cyc_i |-> (sel_i != '0) && (((sel_i + sel_low) & sel_i) == '0))
    else begin
      $error("sel not contiguous");
      fail_count++;
    end

  resp_stable_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (resp_v_i && !resp_ready_i) |=>
      resp_v_i && $stable(resp_header_i) && $stable(resp_data_i))
    else begin
      $error("response valid or payload changed before ready");
      fail_count++;
    end

  c_cmd_stable_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (c_cmd_v_i && !c_cmd_ready_i) |=>
      c_cmd_v_i && $stable(c_cmd_header_i) && $stable(c_cmd_data_i))
    else begin
      $error("client command valid or payload changed before ready");
      fail_count++;
    end

endmodule

bind bedrock_wb_top bedrock_wb_checker checker_i (
  .clk_i          (clk_i),
  .arst_n_i       (arst_n_i),
  .cyc_i          (wb_cyc),
  .stb_i          (wb_stb),
  .ack_i          (wb_ack),
  .sel_i          (wb_sel),
  .resp_header_i  (mem_resp_header_o),
  .resp_data_i    (mem_resp_data_o),
  .resp_v_i       (mem_resp_v_o),
  .resp_ready_i   (mem_resp_ready_and_i),
  .c_cmd_header_i (c_mem_cmd_header_o),
  .c_cmd_data_i   (c_mem_cmd_data_o),
  .c_cmd_v_i      (c_mem_cmd_v_o),
  .c_cmd_ready_i  (c_mem_cmd_ready_and_i)
);

/* test/bedrock_wb_tb.sv */
`timescale 1ns/1ps

module bedrock_wb_tb;

  import bedrock_wb_pkg::*;

  localparam int total_cmds_lp = 16 + 20 + 300 + 3;
  localparam int timeout_cycles_lp = total_cmds_lp * 200 + 5 + 10;

  logic clk, arst_n;
  mem_header_s cmd_hdr, resp_hdr, c_cmd_hdr, c_resp_hdr;
  logic [63:0] cmd_data, resp_data, c_cmd_data, c_resp_data;
  logic cmd_v, cmd_ready, resp_v, resp_ready, hold_resp;
  logic c_cmd_v, c_cmd_ready, c_resp_v, c_resp_ready;

  logic [7:0]  model_mem [256];         // scoreboard view of memory
  logic [7:0]  mem_bytes [256];         // memory behind the client
  mem_beat_s   exp_resp_q [$];
  mem_beat_s   exp_ccmd_q [$];
  logic [31:0] rng = 32'haddc;
  int test_errors, total_errors, tests_run, tests_failed, resp_count, ccmd_count;

  tb_clock_gen clock_gen_i (.clk_o(clk), .arst_n_o(arst_n));

  bedrock_wb_top bedrock_wb_top_i (
    .clk_i(clk), .arst_n_i(arst_n),
    .mem_cmd_header_i(cmd_hdr), .mem_cmd_data_i(cmd_data),
    .mem_cmd_v_i(cmd_v), .mem_cmd_ready_and_o(cmd_ready),
    .mem_resp_header_o(resp_hdr), .mem_resp_data_o(resp_data),
    .mem_resp_v_o(resp_v), .mem_resp_ready_and_i(resp_ready),
    .c_mem_cmd_header_o(c_cmd_hdr), .c_mem_cmd_data_o(c_cmd_data),
    .c_mem_cmd_v_o(c_cmd_v), .c_mem_cmd_ready_and_i(c_cmd_ready),
    .c_mem_resp_header_i(c_resp_hdr), .c_mem_resp_data_i(c_resp_data),
    .c_mem_resp_v_i(c_resp_v), .c_mem_resp_ready_and_o(c_resp_ready)
  );

  function automatic logic [31:0] rand32();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  task automatic expect_true(input bit cond, input string what);
    assert (cond) else begin
      $display("%s", what);
      test_errors++;
    end
  endtask

  task automatic check_beat(input string name, input mem_beat_s exp,
                            input mem_header_s got_h, input logic [63:0] got_d);
    assert (got_h == exp.header) else begin
      $display("CHECK FAILED %s_header got %h exp %h", name, got_h, exp.header);
      test_errors++;
    end
    assert (got_d == exp.data) else begin
      $display("CHECK FAILED %s_data got %h exp %h", name, got_d, exp.data);
      test_errors++;
    end
  endtask

  task automatic rand_cmd(output mem_header_s h, output logic [63:0] d);
    logic [31:0] r;
    r          = rand32();
    h.size     = mem_size_e'(r[1:0]);
    h.msg_type = mem_msg_e'(r[2]);
    h.addr     = {24'h0, r[15:8] & (8'hff << r[1:0])};  // aligned to size
    d          = {rand32(), rand32()};
  endtask

  // drive one command and record what the DUT must do with it
  task automatic send_cmd(input mem_header_s h, input logic [63:0] d);
    mem_beat_s resp, ccmd;
    int nbytes;
    nbytes = 1 << h.size;
    @(posedge clk);
    #1 cmd_hdr = h;
    cmd_data = d;
    cmd_v    = 1'b1;
    do @(posedge clk); while (!cmd_ready);
    resp.header = h;
    resp.data   = '0;
    ccmd.header = h;
    ccmd.data   = '0;
    for (int i = 0; i < nbytes; i++) begin
      ccmd.data[i*8 +: 8] = d[i*8 +: 8];
      if (h.msg_type == e_mem_wr) model_mem[h.addr[7:0] + i] = d[i*8 +: 8];
      else resp.data[i*8 +: 8] = model_mem[h.addr[7:0] + i];
    end
    exp_resp_q.push_back(resp);
    exp_ccmd_q.push_back(ccmd);
    #1 cmd_v = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_resp_q.size() != 0) @(posedge clk);
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors != 0) tests_failed++;
    total_errors += test_errors;
    $display("%s: %s (%0d errors)", name, (test_errors == 0) ? "pass" : "FAIL", test_errors);
    test_errors = 0;
  endtask

  // response side scoreboard and random ready
  initial begin
    resp_ready = 1'b0;
    forever begin
      @(posedge clk);
      if (arst_n && resp_v && resp_ready) begin
        resp_count++;
        if (exp_resp_q.size() == 0) begin
          expect_true(1'b0, "response arrived with no command outstanding");
        end else begin
          check_beat("mem_resp", exp_resp_q.pop_front(), resp_hdr, resp_data);
        end
      end
      #1 resp_ready = hold_resp ? 1'b0 : (rand32() % 4 != 0);
    end
  end

  // memory model behind the client
  initial begin
    mem_header_s h;
    logic [63:0] d, rdata;
    int delay;
    c_cmd_ready = 1'b1;
    c_resp_hdr  = '0;
    c_resp_data = '0;
    c_resp_v    = 1'b0;
    forever begin
      @(posedge clk);
      if (arst_n && c_cmd_v && c_cmd_ready) begin
        h = c_cmd_hdr;
        d = c_cmd_data;
        ccmd_count++;
        if (exp_ccmd_q.size() == 0) expect_true(1'b0, "client command with no master command");
        else check_beat("c_mem_cmd", exp_ccmd_q.pop_front(), h, d);
        rdata = '0;
        for (int i = 0; i < (1 << h.size); i++) begin
          if (h.msg_type == e_mem_wr) mem_bytes[h.addr[7:0] + i] = d[i*8 +: 8];
          else rdata[i*8 +: 8] = mem_bytes[h.addr[7:0] + i];
        end
        delay = int'(rand32() % 5);
        #1 c_cmd_ready = 1'b0;
        repeat (delay) begin
          @(posedge clk);
          #1;
        end
        c_resp_hdr  = h;
        c_resp_data = rdata;
        c_resp_v    = 1'b1;
        do @(posedge clk); while (!c_resp_ready);
        #1 c_resp_v = 1'b0;
        c_cmd_ready = 1'b1;
      end
    end
  end

  initial begin
    repeat (timeout_cycles_lp) @(posedge clk);
    $display("watchdog expired before the tests finished");
    $display("Errors found");
    $finish;
  end

  initial begin
    mem_header_s h;
    logic [63:0] d;
    int start_count, start_ccmd;
    cmd_hdr   = '0;
    cmd_data  = '0;
    cmd_v     = 1'b0;
    hold_resp = 1'b0;
    for (int i = 0; i < 256; i++) begin
      model_mem[i] = 8'(i) ^ 8'h5a;     // fill from the byte address
      mem_bytes[i] = 8'(i) ^ 8'h5a;
    end

    @(posedge clk);
    while (!arst_n) begin
      @(posedge clk);
      expect_true(!resp_v && !c_cmd_v, "response or client command valid during reset");
    end
    @(posedge clk);
    expect_true(!resp_v && !c_cmd_v, "response or client command valid after reset");
    finish_test("test 5 reset state");

    for (int s = 0; s < 4; s++) begin
      for (int k = 0; k < 2; k++) begin
        h.size     = mem_size_e'(s);
        h.addr     = {24'h0, 8'(8'h40 * k + 8 * s + (1 << s) * k)};
        h.msg_type = e_mem_wr;
        d          = {rand32(), rand32()};
        send_cmd(h, d);
        h.msg_type = e_mem_rd;
        send_cmd(h, {rand32(), rand32()});
      end
    end
    wait_drain();
    finish_test("test 1 write then read back");

    start_ccmd = ccmd_count;
    for (int n = 0; n < 20; n++) begin
      rand_cmd(h, d);
      send_cmd(h, d);
    end
    wait_drain();
    expect_true(ccmd_count - start_ccmd == 20, "client command count differs from commands sent");
    expect_true(exp_ccmd_q.size() == 0, "client commands missing");
    finish_test("test 2 client command reconstruction");

    start_count = resp_count;
    for (int n = 0; n < 300; n++) begin
      rand_cmd(h, d);
      send_cmd(h, d);
    end
    wait_drain();
    expect_true(resp_count - start_count == 300, "response count differs from commands sent");
    finish_test("test 3 random mixed traffic");

    hold_resp = 1'b1;
    repeat (2) @(posedge clk);
    start_count = resp_count;
    for (int n = 0; n < 3; n++) begin
      rand_cmd(h, d);
      send_cmd(h, d);
    end
    repeat (40) begin
      @(posedge clk);
      expect_true(!cmd_ready, "command ready rose while the response path was full");
    end
    expect_true(resp_v, "no response waiting while the response path was held");
    hold_resp = 1'b0;
    wait_drain();
    repeat (5) @(posedge clk);
    expect_true(resp_count - start_count == 3, "responses lost or duplicated after release");
    finish_test("test 4 back-pressure");

    total_errors += bedrock_wb_top_i.checker_i.fail_count;
    $display("tests %0d, failed %0d, errors %0d, responses %0d",
             tests_run, tests_failed, total_errors, resp_count);
    if (total_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* test/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;          // 8 ns period
  end

  initial begin
    arst_n_o = 1'b0;
    repeat (5) @(posedge clk_o);
    #1 arst_n_o = 1'b1;
  end

endmodule

/* vlog.f */
rtl/bedrock_wb_pkg.sv
rtl/bedrock_two_fifo.sv
rtl/bedrock_wb_master.sv
rtl/bedrock_wb_client.sv
rtl/bedrock_wb_top.sv
test/tb_clock_gen.sv
test/bedrock_wb_checker.sv
test/bedrock_wb_tb.sv
